// File: hdl/lc4_pkg.sv
// Shared definitions for the LC4 integer subset pipeline
// Opcodes outside the named set decode as a no-write NOP
// NZP codes are one-hot and follow the word that an instruction writes

package lc4_pkg;

   // ========================================================================
   // ISA widths
   // ========================================================================
   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NUM_REGS  = 8;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;
   typedef logic [2:0]           nzp_t;      // {N, Z, P}

   localparam nzp_t NZP_N = 3'b100;
   localparam nzp_t NZP_Z = 3'b010;
   localparam nzp_t NZP_P = 3'b001;

   // Instruction bits 15:12
   typedef enum logic [3:0] {
      OP_NOP   = 4'b0000,
      OP_ARITH = 4'b0001,               // ADD, MUL, SUB, ADD imm5
      OP_LOGIC = 4'b0101,               // AND, NOT, OR, XOR, AND imm5
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_MUL    = 3'd1,
      ALU_SUB    = 3'd2,
      ALU_AND    = 3'd3,
      ALU_NOT    = 3'd4,
      ALU_OR     = 3'd5,
      ALU_XOR    = 3'd6,
      ALU_PASS_B = 3'd7                 // CONST path
   } alu_op_e;

   // ========================================================================
   // Pipeline bundles
   // ========================================================================
   typedef struct packed {
      reg_sel_t rs;
      reg_sel_t rt;
      reg_sel_t rd;
      logic     rs_re;
      logic     rt_re;
      logic     rd_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      alu_op_e  alu_op;
      logic     imm_sel;                // b operand taken from imm
      word_t    imm;                    // Already sign-extended
   } ctrl_t;

   typedef struct packed {
      word_t addr;
      logic  we;
      word_t wdata;
   } dmem_req_t;

   // One retiring instruction, as seen at writeback
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_sel_t wsel;
      word_t    wdata;
      logic     nzp_we;
      nzp_t     nzp_bits;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;              // Store data or load data
   } trace_t;

   // Condition codes of a written word
   function automatic nzp_t nzp_of(input word_t value);
      if (value[WORD_W-1]) begin
         return NZP_N;
      end else if (value == '0) begin
         return NZP_Z;
      end
      return NZP_P;
   endfunction

endpackage

// File: hdl/lc4_decoder.sv
// Combinational decode for the supported LC4 subset
// DIV, shifts, compares and all control flow come out with every enable low
// nzp_we always follows rd_we

`timescale 1ns/1ps

module lc4_decoder (
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t o_ctrl
);
   import lc4_pkg::*;

   opcode_e    opcode;
   logic [2:0] sub_op;
   word_t      imm5;
   word_t      imm6;
   word_t      imm9;

   assign opcode = opcode_e'(i_insn[15:12]);
   assign sub_op = i_insn[5:3];
   assign imm5   = {{(WORD_W-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6   = {{(WORD_W-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9   = {{(WORD_W-9){i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      logic rr;                         // Register-register form accepted
      rr            = 1'b0;
      o_ctrl        = '0;
      o_ctrl.rd     = i_insn[11:9];
      o_ctrl.rs     = i_insn[8:6];
      o_ctrl.rt     = i_insn[2:0];
      o_ctrl.alu_op = ALU_ADD;
      case (opcode)
         OP_ARITH: begin
            if (i_insn[5]) begin        // ADD rd, rs, imm5
               o_ctrl.imm_sel = 1'b1;
               o_ctrl.imm     = imm5;
               o_ctrl.rs_re   = 1'b1;
               o_ctrl.rd_we   = 1'b1;
            end else begin
               case (sub_op)
                  3'b000:  o_ctrl.alu_op = ALU_ADD;
                  3'b001:  o_ctrl.alu_op = ALU_MUL;
                  3'b010:  o_ctrl.alu_op = ALU_SUB;
                  default: o_ctrl.alu_op = ALU_PASS_B;
               endcase
               rr = (sub_op != 3'b011); // DIV retires as NOP
            end
         end
         OP_LOGIC: begin
            if (i_insn[5]) begin        // AND rd, rs, imm5
               o_ctrl.alu_op  = ALU_AND;
               o_ctrl.imm_sel = 1'b1;
               o_ctrl.imm     = imm5;
               o_ctrl.rs_re   = 1'b1;
               o_ctrl.rd_we   = 1'b1;
            end else begin
               case (sub_op)
                  3'b000:  o_ctrl.alu_op = ALU_AND;
                  3'b001:  o_ctrl.alu_op = ALU_NOT;
                  3'b010:  o_ctrl.alu_op = ALU_OR;
                  default: o_ctrl.alu_op = ALU_XOR;
               endcase
               rr = 1'b1;
            end
         end
         OP_LDR: begin                  // rd = mem[rs + imm6]
            o_ctrl.imm_sel = 1'b1;
            o_ctrl.imm     = imm6;
            o_ctrl.rs_re   = 1'b1;
            o_ctrl.rd_we   = 1'b1;
            o_ctrl.is_load = 1'b1;
         end
         OP_STR: begin                  // mem[rs + imm6] = rt
            o_ctrl.rt       = i_insn[11:9];
            o_ctrl.imm_sel  = 1'b1;
            o_ctrl.imm      = imm6;
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
         end
         OP_CONST: begin
            o_ctrl.alu_op  = ALU_PASS_B;
            o_ctrl.imm_sel = 1'b1;
            o_ctrl.imm     = imm9;
            o_ctrl.rd_we   = 1'b1;
         end
         default: ;                     // NOP and everything dropped
      endcase
      if (rr) begin
         o_ctrl.rs_re = 1'b1;
         o_ctrl.rt_re = (o_ctrl.alu_op != ALU_NOT);
         o_ctrl.rd_we = 1'b1;
      end
      o_ctrl.nzp_we = o_ctrl.rd_we;
   end

   // Load and store are exclusive
   always_comb begin
      assert (!(o_ctrl.is_load && o_ctrl.is_store))
         else $error("decoder: load and store both set for insn %h", i_insn);
   end

endmodule

// File: hdl/lc4_regfile.sv
// Eight 16-bit registers, two read ports and one write port
// Reads are combinational, a write lands on the gwe edge
// A read of the register being written returns the new data

`timescale 1ns/1ps

module lc4_regfile (
   input  logic             gwe,
   input  logic             i_reset,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   input  lc4_pkg::reg_sel_t i_rd_sel,
   input  logic             i_rd_we,
   input  lc4_pkg::word_t   i_wdata,
   output lc4_pkg::word_t   o_rs_data,
   output lc4_pkg::word_t   o_rt_data
);
   import lc4_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   // WD bypass, writeback and decode share the cycle
   assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

// File: hdl/lc4_alu.sv
// Combinational LC4 ALU for the supported subset
// Also forms LDR/STR addresses (ADD with offset) and CONST values (PASS_B)
// MUL keeps only the low word

`timescale 1ns/1ps

module lc4_alu (
   input  lc4_pkg::alu_op_e i_op,
   input  lc4_pkg::word_t   i_a,        // rs
   input  lc4_pkg::word_t   i_b,        // rt
   input  lc4_pkg::word_t   i_imm,      // Sign-extended immediate
   input  logic             i_imm_sel,
   output lc4_pkg::word_t   o_result
);
   import lc4_pkg::*;

   word_t op_b;
   word_t product;

   // Immediate forms replace rt
   assign op_b    = i_imm_sel ? i_imm : i_b;
   assign product = i_a * op_b;         // Low 16 bits only

   always_comb begin
      case (i_op)
         ALU_ADD: begin
            o_result = i_a + op_b;      // Also effective address
         end
         ALU_MUL: begin
            o_result = product;
         end
         ALU_SUB: begin
            o_result = i_a - op_b;
         end
         ALU_AND: begin
            o_result = i_a & op_b;
         end
         ALU_NOT: begin
            o_result = ~i_a;
         end
         ALU_OR: begin
            o_result = i_a | op_b;
         end
         ALU_XOR: begin
            o_result = i_a ^ op_b;
         end
         ALU_PASS_B: begin
            o_result = op_b;            // CONST
         end
         default: begin
            o_result = '0;
         end
      endcase
   end

endmodule

// File: hdl/lc4_execute.sv
// Execute stage with MX/WX operand bypass, the ALU and the NZP register
// MX wins over WX, both only for a producer that writes a register
// The NZP register holds the codes of the instruction now in memory
// For a load it holds address codes, the memory stage substitutes load data

`timescale 1ns/1ps

module lc4_execute (
   input  logic             gwe,
   input  logic             i_reset,
   input  lc4_pkg::ctrl_t   i_ctrl,
   input  lc4_pkg::word_t   i_pc,
   input  lc4_pkg::word_t   i_rs_data,
   input  lc4_pkg::word_t   i_rt_data,
   input  lc4_pkg::word_t   i_m_fwd,    // Memory stage result or load data
   input  lc4_pkg::reg_sel_t i_m_rd,
   input  logic             i_m_we,
   input  lc4_pkg::word_t   i_w_fwd,    // Writeback result
   input  lc4_pkg::reg_sel_t i_w_rd,
   input  logic             i_w_we,
   output lc4_pkg::word_t   o_result,
   output lc4_pkg::word_t   o_rt_fwd,   // Store data after bypass
   output lc4_pkg::nzp_t    o_nzp
);
   import lc4_pkg::*;

   word_t rs_val;
   word_t rt_val;
   nzp_t  nzp_q;

   // ========================================================================
   // Operand bypass
   // ========================================================================
   assign rs_val = (i_ctrl.rs_re && i_m_we && (i_m_rd == i_ctrl.rs)) ? i_m_fwd :    // MX
                   (i_ctrl.rs_re && i_w_we && (i_w_rd == i_ctrl.rs)) ? i_w_fwd :    // WX
                   i_rs_data;
   assign rt_val = (i_ctrl.rt_re && i_m_we && (i_m_rd == i_ctrl.rt)) ? i_m_fwd :    // MX
                   (i_ctrl.rt_re && i_w_we && (i_w_rd == i_ctrl.rt)) ? i_w_fwd :    // WX
                   i_rt_data;

   assign o_rt_fwd = rt_val;

   lc4_alu u_alu (
      .i_op      (i_ctrl.alu_op),
      .i_a       (rs_val),
      .i_b       (rt_val),
      .i_imm     (i_ctrl.imm),
      .i_imm_sel (i_ctrl.imm_sel),
      .o_result  (o_result)
   );

   // Updates at the end of this stage's cycle
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_q <= '0;
      end else if (i_ctrl.nzp_we) begin
         nzp_q <= nzp_of(o_result);
      end
   end

   assign o_nzp = nzp_q;

   // A writing instruction leaves one code set when it reaches memory
   assert property (@(posedge gwe) disable iff (i_reset)
      i_ctrl.nzp_we |=> $onehot(o_nzp));

endmodule

// File: hdl/lc4_pipeline.sv
// Five-stage LC4 subset pipeline with no control flow, the PC only counts up
// IMEM and DMEM are combinational and sit outside, stores write on the next edge
// Load data forwards straight into execute, so nothing ever stalls
// An instruction fetched in cycle n shows on o_trace in cycle n+4

`timescale 1ns/1ps

module lc4_pipeline #(
   parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
   input  logic               gwe,
   input  logic               i_reset,
   input  lc4_pkg::word_t     i_cur_insn,       // Same-cycle IMEM data
   input  lc4_pkg::word_t     i_cur_dmem_data,  // Same-cycle DMEM data
   output lc4_pkg::word_t     o_cur_pc,
   output lc4_pkg::dmem_req_t o_dmem,           // From memory stage
   output lc4_pkg::trace_t    o_trace           // From writeback
);
   import lc4_pkg::*;

   word_t pc;
   // Decode
   logic  d_valid;
   word_t d_pc;
   word_t d_insn;
   ctrl_t dec_ctrl;
   word_t rf_rs_data;
   word_t rf_rt_data;
   // Execute
   logic  x_valid;
   word_t x_pc;
   word_t x_insn;
   ctrl_t x_ctrl;
   word_t x_rs_data;
   word_t x_rt_data;
   word_t ex_result;
   word_t ex_rt_fwd;
   nzp_t  ex_nzp;
   // Memory
   logic  m_valid;
   word_t m_pc;
   word_t m_insn;
   ctrl_t m_ctrl;
   word_t m_alu;
   word_t m_rt_data;
   word_t m_store_data;
   word_t m_fwd;
   nzp_t  m_nzp;
   // Writeback
   logic  w_valid;
   word_t w_pc;
   word_t w_insn;
   ctrl_t w_ctrl;
   word_t w_alu;
   word_t w_load_data;
   word_t w_dmem_addr;
   word_t w_store_data;
   nzp_t  w_nzp;
   word_t w_word;                       // Value written to rd

   // ========================================================================
   // Fetch
   // ========================================================================
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc <= RESET_PC;
      end else begin
         pc <= pc + 16'd1;
      end
   end

   assign o_cur_pc = pc;

   // ========================================================================
   // Decode and execute
   // ========================================================================
   lc4_decoder u_decoder (
      .i_insn (d_insn),
      .o_ctrl (dec_ctrl)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs_sel  (dec_ctrl.rs),
      .i_rt_sel  (dec_ctrl.rt),
      .i_rd_sel  (w_ctrl.rd),
      .i_rd_we   (w_ctrl.rd_we),
      .i_wdata   (w_word),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   lc4_execute u_execute (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_ctrl    (x_ctrl),
      .i_pc      (x_pc),
      .i_rs_data (x_rs_data),
      .i_rt_data (x_rt_data),
      .i_m_fwd   (m_fwd),
      .i_m_rd    (m_ctrl.rd),
      .i_m_we    (m_ctrl.rd_we),
      .i_w_fwd   (w_word),
      .i_w_rd    (w_ctrl.rd),
      .i_w_we    (w_ctrl.rd_we),
      .o_result  (ex_result),
      .o_rt_fwd  (ex_rt_fwd),
      .o_nzp     (ex_nzp)
   );

   // ========================================================================
   // Stage registers, control cleared to NOP bubbles on reset
   // ========================================================================
   always_ff @(posedge gwe) begin
      d_pc         <= pc;
      x_pc         <= d_pc;
      x_insn       <= d_insn;
      x_rs_data    <= rf_rs_data;
      x_rt_data    <= rf_rt_data;
      m_pc         <= x_pc;
      m_insn       <= x_insn;
      m_alu        <= ex_result;
      m_rt_data    <= ex_rt_fwd;
      w_pc         <= m_pc;
      w_insn       <= m_insn;
      w_alu        <= m_alu;
      w_load_data  <= i_cur_dmem_data;
      w_dmem_addr  <= o_dmem.addr;
      w_store_data <= o_dmem.wdata;
      w_nzp        <= m_nzp;
      if (i_reset) begin
         d_valid <= 1'b0;
         d_insn  <= '0;                 // Opcode 0000 decodes as NOP
         x_valid <= 1'b0;
         x_ctrl  <= '0;
         m_valid <= 1'b0;
         m_ctrl  <= '0;
         w_valid <= 1'b0;
         w_ctrl  <= '0;
      end else begin
         d_valid <= 1'b1;
         d_insn  <= i_cur_insn;
         x_valid <= d_valid;
         x_ctrl  <= dec_ctrl;
         m_valid <= x_valid;
         m_ctrl  <= x_ctrl;
         w_valid <= m_valid;
         w_ctrl  <= m_ctrl;
      end
   end

   // ========================================================================
   // Memory stage
   // ========================================================================
   // WM bypass of store data
   assign m_store_data = (m_ctrl.is_store && w_ctrl.rd_we && (w_ctrl.rd == m_ctrl.rt))
                         ? w_word : m_rt_data;

   always_comb begin
      o_dmem.we    = m_ctrl.is_store;
      o_dmem.addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_alu : '0;
      o_dmem.wdata = m_ctrl.is_store ? m_store_data : '0;
   end

   assign m_fwd = m_ctrl.is_load ? i_cur_dmem_data : m_alu;      // MX source
   assign m_nzp = m_ctrl.is_load ? nzp_of(i_cur_dmem_data) : ex_nzp;

   // ========================================================================
   // Writeback and trace
   // ========================================================================
   assign w_word = w_ctrl.is_load ? w_load_data : w_alu;

   // Unused fields read as zero
   always_comb begin
      o_trace.valid      = w_valid;
      o_trace.pc         = w_pc;
      o_trace.insn       = w_insn;
      o_trace.regfile_we = w_ctrl.rd_we;
      o_trace.wsel       = w_ctrl.rd_we ? w_ctrl.rd : '0;
      o_trace.wdata      = w_ctrl.rd_we ? w_word : '0;
      o_trace.nzp_we     = w_ctrl.nzp_we;
      o_trace.nzp_bits   = w_ctrl.nzp_we ? w_nzp : '0;
      o_trace.dmem_we    = w_ctrl.is_store;
      o_trace.dmem_addr  = w_dmem_addr;
      o_trace.dmem_data  = w_ctrl.is_store ? w_store_data :
                           w_ctrl.is_load  ? w_load_data  : '0;
   end

endmodule

// File: bench/lc4_tb.sv
// Directed and random testbench for the LC4 subset pipeline
// IMEM and DMEM are combinational arrays, a store lands on the next gwe edge
// Expected traces come from an in-order ISA model run over the loaded program
// Programs are padded with NOPs, so fetches past the end retire harmlessly

`timescale 1ns/1ps

module lc4_tb;
   import lc4_pkg::*;

   localparam word_t       BASE_PC     = 16'h8200;
   localparam int          CLK_PERIOD  = 100;
   localparam int          IMEM_WORDS  = 128;
   localparam int          DMEM_WORDS  = 256;
   localparam int          NUM_TESTS   = 5;
   localparam int          MAX_INSNS   = 70;      // Sum of all program lengths
   localparam int          CYCLE_LIMIT = MAX_INSNS + NUM_TESTS * 20;
   localparam int unsigned SEED        = 32'h71d17b36;

   logic      gwe;
   logic      i_reset;
   word_t     i_cur_insn;
   word_t     i_cur_dmem_data;
   word_t     o_cur_pc;
   dmem_req_t o_dmem;
   trace_t    o_trace;

   word_t      imem [IMEM_WORDS];
   word_t      dmem [DMEM_WORDS];
   word_t      model_mem [DMEM_WORDS];
   word_t      model_regs [NUM_REGS];
   trace_t     expected [$];
   word_t      pc_off;
   int         prog_len;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;
   string      test_name;
   logic [3:0] unsup_ops [11] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h8, 4'hA,
                                  4'hB, 4'hC, 4'hD, 4'hE, 4'hF};

   lc4_pipeline #(.RESET_PC(BASE_PC)) u_dut (
      .gwe             (gwe),
      .i_reset         (i_reset),
      .i_cur_insn      (i_cur_insn),
      .i_cur_dmem_data (i_cur_dmem_data),
      .o_cur_pc        (o_cur_pc),
      .o_dmem          (o_dmem),
      .o_trace         (o_trace)
   );

   // ========================================================================
   // Clock, memories, timeout
   // ========================================================================
   always #(CLK_PERIOD / 2) gwe = ~gwe;

   assign pc_off          = o_cur_pc - BASE_PC;
   assign i_cur_insn      = (pc_off < word_t'(IMEM_WORDS)) ? imem[pc_off[6:0]] : '0;
   assign i_cur_dmem_data = dmem[o_dmem.addr[7:0]];    // Only low byte decodes

   always @(posedge gwe) begin
      if (o_dmem.we) begin
         dmem[o_dmem.addr[7:0]] <= o_dmem.wdata;
      end
   end

   always @(posedge gwe) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   // ========================================================================
   // Encoders and model helpers
   // ========================================================================
   function automatic word_t rr_insn(int op, int sub, int rd, int rs, int rt);
      return {op[3:0], rd[2:0], rs[2:0], 1'b0, sub[1:0], rt[2:0]};
   endfunction

   function automatic word_t imm5_insn(int op, int rd, int rs, int imm);
      return {op[3:0], rd[2:0], rs[2:0], 1'b1, imm[4:0]};
   endfunction

   function automatic word_t mem_insn(int op, int r, int rs, int off);
      return {op[3:0], r[2:0], rs[2:0], off[5:0]};
   endfunction

   function automatic word_t const_insn(int rd, int imm);
      return {4'b1001, rd[2:0], imm[8:0]};
   endfunction

   // Whole 8-bit address shows in the word
   function automatic word_t fill_word(int a);
      return {a[7:0], ~a[7:0]} ^ 16'h3c96;
   endfunction

   function automatic nzp_t expected_nzp(word_t v);
      if (v[15]) begin
         return 3'b100;
      end else if (v == 16'h0000) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

   task automatic emit(word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   // In-order ISA reference, one trace per program word
   task automatic build_model();
      trace_t t;
      word_t  insn;
      word_t  a;
      word_t  b;
      word_t  res;
      word_t  addr;
      logic   wr;
      for (int r = 0; r < NUM_REGS; r++) begin
         model_regs[r] = '0;                       // Regfile clears on reset
      end
      for (int m = 0; m < DMEM_WORDS; m++) begin
         model_mem[m] = fill_word(m);
      end
      expected.delete();
      for (int i = 0; i < prog_len; i++) begin
         insn    = imem[i];
         t       = '0;
         t.valid = 1'b1;
         t.pc    = BASE_PC + word_t'(i);
         t.insn  = insn;
         a       = model_regs[insn[8:6]];
         b       = model_regs[insn[2:0]];
         wr      = 1'b0;
         res     = '0;
         case (insn[15:12])
            4'b0001: begin
               wr = 1'b1;
               if (insn[5]) begin
                  res = a + {{11{insn[4]}}, insn[4:0]};
               end else if (insn[4:3] == 2'd0) begin
                  res = a + b;
               end else if (insn[4:3] == 2'd1) begin
                  res = a * b;
               end else if (insn[4:3] == 2'd2) begin
                  res = a - b;
               end else begin
                  wr = 1'b0;                       // DIV is not supported
               end
            end
            4'b0101: begin
               wr = 1'b1;
               if (insn[5]) begin
                  res = a & {{11{insn[4]}}, insn[4:0]};
               end else if (insn[4:3] == 2'd0) begin
                  res = a & b;
               end else if (insn[4:3] == 2'd1) begin
                  res = ~a;
               end else if (insn[4:3] == 2'd2) begin
                  res = a | b;
               end else begin
                  res = a ^ b;
               end
            end
            4'b0110: begin
               addr        = a + {{10{insn[5]}}, insn[5:0]};
               res         = model_mem[addr[7:0]];
               wr          = 1'b1;
               t.dmem_addr = addr;
               t.dmem_data = res;
            end
            4'b0111: begin
               addr                  = a + {{10{insn[5]}}, insn[5:0]};
               t.dmem_we             = 1'b1;
               t.dmem_addr           = addr;
               t.dmem_data           = model_regs[insn[11:9]];
               model_mem[addr[7:0]]  = t.dmem_data;
            end
            4'b1001: begin
               res = {{7{insn[8]}}, insn[8:0]};
               wr  = 1'b1;
            end
            default: ;                             // Retires as NOP
         endcase
         if (wr) begin
            t.regfile_we            = 1'b1;
            t.wsel                  = insn[11:9];
            t.wdata                 = res;
            t.nzp_we                = 1'b1;
            t.nzp_bits              = expected_nzp(res);
            model_regs[insn[11:9]]  = res;
         end
         expected.push_back(t);
      end
   endtask

   // ========================================================================
   // Compare tasks
   // ========================================================================
   task automatic check_word(string what, word_t exp, word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_nzp(string what, nzp_t exp, nzp_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_trace(string what, trace_t exp, trace_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   // Bubbles only, nothing may write
   task automatic check_idle(string where);
      checks++;
      if (o_trace.valid !== 1'b0 || o_trace.regfile_we !== 1'b0 ||
          o_trace.nzp_we !== 1'b0 || o_dmem.we !== 1'b0) begin
         errors++;
         $display("Test %s: pipeline is not idle %s", test_name, where);
      end
   endtask

   // ========================================================================
   // Test sequencing
   // ========================================================================
   task automatic start_test(string name);
      @(negedge gwe);
      i_reset   = 1'b1;
      test_name = name;
      prog_len  = 0;
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = '0;
      end
   endtask

   // Reset, release, then follow retirement in program order
   task automatic run_program();
      int     cyc;
      int     idx;
      trace_t exp_t;
      build_model();
      for (int m = 0; m < DMEM_WORDS; m++) begin
         dmem[m] <= fill_word(m);
      end
      repeat (2) begin
         @(negedge gwe);
         check_idle("during reset");
         check_word("reset pc", BASE_PC, o_cur_pc);
      end
      i_reset = 1'b0;
      cyc     = 0;
      idx     = 0;
      while (idx < prog_len && cyc <= prog_len + 20) begin
         check_word("pc", BASE_PC + word_t'(cyc), o_cur_pc);
         if (cyc < 4) begin
            check_idle("before the first retirement");
         end
         if (o_trace.valid === 1'b1) begin
            if (idx == 0 && cyc != 4) begin
               errors++;
               $display("Test %s: first instruction retired in cycle %0d, not 4",
                        test_name, cyc);
            end
            exp_t = expected[idx];
            check_word("wdata", exp_t.wdata, o_trace.wdata);
            check_nzp("nzp_bits", exp_t.nzp_bits, o_trace.nzp_bits);
            check_trace("trace", exp_t, o_trace);
            idx++;
         end
         if (idx < prog_len) begin
            @(negedge gwe);
            cyc++;
         end
      end
      if (idx < prog_len) begin
         errors++;
         $display("Test %s: only %0d of %0d instructions retired", test_name, idx, prog_len);
      end
      for (int m = 0; m < DMEM_WORDS; m++) begin
         check_word($sformatf("dmem[%0d]", m), model_mem[m], dmem[m]);
      end
   endtask

   // ========================================================================
   // Directed tests
   // ========================================================================
   task automatic test_reset();
      start_test("reset");
      emit(const_insn(1, 5));
      emit(rr_insn(1, 0, 2, 1, 1));               // Needs r1 through MX
      emit(16'h0000);
      run_program();
   endtask

   task automatic test_forwarding();
      start_test("forwarding");
      emit(const_insn(1, 3));
      emit(const_insn(2, -2));
      emit(rr_insn(1, 0, 3, 1, 2));               // r2 by MX, r1 by WX
      emit(rr_insn(1, 1, 4, 3, 3));               // MUL
      emit(rr_insn(1, 2, 5, 4, 1));               // SUB
      emit(rr_insn(5, 0, 6, 5, 3));               // AND
      emit(rr_insn(5, 1, 7, 6, 0));               // NOT
      emit(rr_insn(5, 2, 1, 7, 2));               // OR
      emit(rr_insn(5, 3, 2, 1, 7));               // XOR
      run_program();
   endtask

   task automatic test_immediates();
      start_test("immediates");
      emit(const_insn(1, -256));                  // Most negative imm9
      emit(const_insn(2, 0));
      emit(const_insn(3, 255));
      emit(imm5_insn(1, 4, 1, -16));
      emit(imm5_insn(5, 5, 3, 15));
      emit(imm5_insn(1, 6, 2, 0));                // Z result
      emit(rr_insn(1, 0, 7, 4, 6));               // r4 through WD bypass
      run_program();
   endtask

   task automatic test_memory();
      start_test("memory");
      emit(const_insn(1, 16));                    // Base
      emit(const_insn(2, -7));
      emit(imm5_insn(1, 3, 2, 3));
      emit(mem_insn(7, 3, 1, 5));                 // Store data from previous insn
      emit(mem_insn(6, 4, 1, 5));
      emit(rr_insn(1, 0, 5, 4, 4));               // Load-use
      emit(mem_insn(7, 5, 1, -3));
      emit(mem_insn(6, 6, 1, -3));
      emit(mem_insn(6, 7, 1, 0));
      emit(mem_insn(7, 7, 1, 1));                 // Load data straight to store
      emit(mem_insn(6, 2, 1, 1));
      run_program();
   endtask

   task automatic test_random();
      int    kind;
      int    rd;
      int    rs;
      int    rt;
      word_t w;
      start_test("random");
      while (prog_len < 40) begin
         kind = int'($urandom_range(0, 7));
         rd   = int'($urandom_range(0, 7));
         rs   = int'($urandom_range(0, 7));
         rt   = int'($urandom_range(0, 7));
         case (kind)
            0: emit(const_insn(rd, int'($urandom_range(0, 511)) - 256));
            1: emit(rr_insn(1, int'($urandom_range(0, 2)), rd, rs, rt));
            2: emit(imm5_insn(1, rd, rs, int'($urandom_range(0, 31))));
            3: emit(rr_insn(5, int'($urandom_range(0, 3)), rd, rs, rt));
            4: emit(imm5_insn(5, rd, rs, int'($urandom_range(0, 31))));
            5, 6: begin
               if (prog_len <= 38) begin
                  // Base 64..191 plus offset stays inside DMEM
                  emit(const_insn(rs, 64 + int'($urandom_range(0, 127))));
                  emit(mem_insn((kind == 5) ? 6 : 7, rd, rs, int'($urandom_range(0, 63))));
               end
            end
            default: begin
               if ($urandom_range(0, 3) == 0) begin
                  emit(rr_insn(1, 3, rd, rs, rt));  // DIV
               end else begin
                  w        = word_t'($urandom);
                  w[15:12] = unsup_ops[$urandom_range(0, 10)];
                  emit(w);
               end
            end
         endcase
      end
      run_program();
   endtask

   initial begin
      void'($urandom(SEED));
      gwe        = 1'b0;
      i_reset    = 1'b1;
      test_name  = "init";
      prog_len   = 0;
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = '0;
      end
      test_reset();
      test_forwarding();
      test_immediates();
      test_memory();
      test_random();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: files.f
hdl/lc4_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile.sv
hdl/lc4_alu.sv
hdl/lc4_execute.sv
hdl/lc4_pipeline.sv
bench/lc4_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module lc4_tb \
   -Mdir obj_dir -o lc4_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/lc4_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
   exit 0
fi
exit 1
